//--- bench/credit_counter_tb.sv
`timescale 1ns/1ps

module credit_counter_tb
    import router_geom_pkg::*, credit_pkg::*;
;

    localparam int N_TABLE = 27;
    localparam int N_RAND  = 200;
    localparam int LIMIT   = N_TABLE + N_RAND + 20;  // cycles before timeout

    typedef enum logic [2:0] {
        K_NONE, K_CIN, K_ALLOC, K_FLIT, K_TAIL, K_CINFLIT, K_GRANT,
        K_UNASSIGNED
    } step_kind_e;

    typedef struct packed {
        step_kind_e    kind;
        logic [4:0]    idx;       // ovc for K_CIN and K_ALLOC, ivc otherwise
        logic          has_exp;
        logic [PV-1:0] exp_avail;
        logic [PV-1:0] exp_not_full;
    } step_t;

    logic clk = 1'b0;
    logic reset;
    logic [PV-1:0]    flit_is_tail_all;
    logic [PVV-1:0]   assigned_ovc_num_all;
    logic [PV-1:0]    ovc_is_assigned_all;
    logic [PP_1-1:0]  granted_dest_port_all;
    logic [PV-1:0]    first_arbiter_granted_ivc_all;
    logic [PV-1:0]    credit_in_all;
    logic [PV-1:0]    ovc_allocated_all;
    logic [PVP_1-1:0] dest_port_all;
    logic [PV-1:0]    ivc_getting_sw_grant;
    logic [PV-1:0]    ovc_available_all;
    logic [PV-1:0]    assigned_ovc_not_full_all;

    step_t       steps[$];
    credit_t     m_cnt [PV];   // reference model of the bank
    ovc_state_e  m_st  [PV];
    logic [PV-1:0] m_full;
    logic [PV-1:0] m_nf;
    logic [PV-1:0] m_full_q;
    logic [PV-1:0] m_nfg_q;
    int unsigned lcg_state = 91635;
    int          cycle_cnt = 0;

    credit_counter_top i_credit_counter_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            stop_run("timeout, the step loop did not finish in time");
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_available(input logic [PV-1:0] got, input logic [PV-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] ovc_available_all got %h expected %h", got, exp));
        end
    endtask

    task automatic check_not_full(input logic [PV-1:0] got, input logic [PV-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] assigned_ovc_not_full_all got %h expected %h", got, exp));
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // group of the next port in the view of source port p
    function automatic int dest_group(input int p);
        int d;
        d = (p + 1) % P_NUM;
        return (d < p) ? d : d - 1;
    endfunction

    // every ivc is assigned the same vc on the next port
    function automatic int ovc_of(input int i);
        return ((i / V_NUM + 1) % P_NUM) * V_NUM + i % V_NUM;
    endfunction

    function automatic int step_ovc(input step_t s);
        if (s.kind == K_CIN || s.kind == K_ALLOC) begin
            return int'(s.idx);
        end
        return ovc_of(int'(s.idx));
    endfunction

    function automatic logic is_flit(input step_t s);
        return s.kind == K_FLIT || s.kind == K_TAIL || s.kind == K_CINFLIT;
    endfunction

    function automatic step_t table_row(input step_kind_e kind, input int idx,
                                        input logic [PV-1:0] avail, input logic [PV-1:0] nf);
        step_t s;
        s.kind         = kind;
        s.idx          = 5'(idx);
        s.has_exp      = 1'b1;
        s.exp_avail    = avail;
        s.exp_not_full = nf;
        return s;
    endfunction

    function automatic logic [PV-1:0] model_avail();
        logic [PV-1:0] a;
        for (int k = 0; k < PV; k++) begin
            a[k] = (m_st[k] == OVC_FREE) && !m_nf[k];
        end
        return a;
    endfunction

    // illegal picks turn into idle steps
    function automatic step_t random_step();
        step_t s;
        int    k;
        logic  ok;
        s      = '0;
        s.kind = step_kind_e'(3'(lcg_next() % 8));
        s.idx  = 5'(lcg_next() % PV);
        k      = step_ovc(s);
        case (s.kind)
            K_CIN:          ok = m_cnt[k] < CRD_MAX;
            K_ALLOC:        ok = m_st[k] == OVC_FREE && m_cnt[k] != '0;
            K_FLIT, K_TAIL: ok = m_cnt[k] != '0;
            K_CINFLIT:      ok = m_cnt[k] != '0 && m_cnt[k] < CRD_MAX;
            default:        ok = 1'b1;
        endcase
        if (!ok) begin
            s.kind = K_NONE;
        end
        return s;
    endfunction

    task automatic drive_step(input step_t s);
        logic [PV-1:0]   cin;
        logic [PV-1:0]   alloc;
        logic [PV-1:0]   tail;
        logic [PV-1:0]   arb;
        logic [PV-1:0]   grant;
        logic [PV-1:0]   asg;
        logic [PP_1-1:0] gdp;
        int              i;
        int              k;
        cin   = '0;
        alloc = '0;
        tail  = '0;
        arb   = '0;
        grant = '0;
        asg   = '1;
        gdp   = '0;
        i     = int'(s.idx);
        k     = step_ovc(s);
        if (s.kind == K_CIN || s.kind == K_CINFLIT) cin[k] = 1'b1;
        if (s.kind == K_ALLOC) alloc[k] = 1'b1;
        if (s.kind == K_TAIL || s.kind == K_UNASSIGNED) tail[i] = 1'b1;
        if (s.kind == K_UNASSIGNED) asg[i] = 1'b0;  // winner holds no ovc
        if (is_flit(s) || s.kind == K_UNASSIGNED) begin
            arb[i] = 1'b1;
            gdp[(i / V_NUM) * P_1 + dest_group(i / V_NUM)] = 1'b1;
        end
        if (is_flit(s) || s.kind == K_GRANT) grant[i] = 1'b1;
        credit_in_all                 <= cin;
        ovc_allocated_all             <= alloc;
        flit_is_tail_all              <= tail;
        first_arbiter_granted_ivc_all <= arb;
        granted_dest_port_all         <= gdp;
        ivc_getting_sw_grant          <= grant;
        ovc_is_assigned_all           <= asg;
    endtask

    // mask registers see the flags from before the edge
    task automatic model_update(input step_t s);
        int k;
        logic cin;
        logic dec;
        k = step_ovc(s);
        for (int i = 0; i < PV; i++) begin
            cin = (s.kind == K_CIN || s.kind == K_CINFLIT) && ovc_of(i) == k;
            m_full_q[i] = m_full[ovc_of(i)] & ~cin;
            m_nfg_q[i]  = m_nf[ovc_of(i)] & ~cin & (int'(s.idx) == i)
                          & (is_flit(s) || s.kind == K_GRANT);
        end
        cin = s.kind == K_CIN || s.kind == K_CINFLIT;
        dec = is_flit(s) || s.kind == K_ALLOC;
        if (cin && !dec) m_cnt[k] = m_cnt[k] + credit_t'(1);
        if (dec && !cin) m_cnt[k] = m_cnt[k] - credit_t'(1);
        if (s.kind == K_ALLOC) m_st[k] = OVC_ALLOCATED;
        if (s.kind == K_TAIL) m_st[k] = OVC_FREE;
        for (int j = 0; j < PV; j++) begin
            m_full[j] = m_cnt[j] == '0;
            m_nf[j]   = m_cnt[j] <= NEARLY_FULL_LIMIT;
        end
    endtask

    initial begin
        reset = 1'b1;
        assigned_ovc_num_all = '0;
        dest_port_all        = '0;
        drive_step('0);
        for (int i = 0; i < PV; i++) begin
            assigned_ovc_num_all[i * V_NUM + i % V_NUM] = 1'b1;
            dest_port_all[i * P_1 + dest_group(i / V_NUM)] = 1'b1;
            m_cnt[i] = CRD_MAX;
            m_st[i]  = OVC_FREE;
        end
        {m_full, m_nf, m_full_q, m_nfg_q} = '0;

        // ivc 0 feeds ovc 4 and ivc 16 feeds ovc 0
        steps.push_back(table_row(K_NONE,       0,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_ALLOC,      4,  20'hFFFEF, 20'hFFFFF));
        steps.push_back(table_row(K_UNASSIGNED, 0,  20'hFFFEF, 20'hFFFFF));  // nothing taken
        steps.push_back(table_row(K_TAIL,       0,  20'hFFFFF, 20'hFFFFF));  // released
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_FLIT,       0,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_FLIT,       0,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_FLIT,       0,  20'hFFFEF, 20'hFFFFF));  // one credit left
        steps.push_back(table_row(K_NONE,       0,  20'hFFFEF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_FLIT,       0,  20'hFFFEF, 20'hFFFFF));
        steps.push_back(table_row(K_GRANT,      0,  20'hFFFEF, 20'hFFFFE));  // nearly full
        steps.push_back(table_row(K_NONE,       0,  20'hFFFEF, 20'hFFFFF));
        steps.push_back(table_row(K_FLIT,       0,  20'hFFFEF, 20'hFFFFE));  // last credit used
        steps.push_back(table_row(K_NONE,       0,  20'hFFFEF, 20'hFFFFE));
        steps.push_back(table_row(K_NONE,       0,  20'hFFFEF, 20'hFFFFE));
        steps.push_back(table_row(K_CIN,        4,  20'hFFFEF, 20'hFFFFF));
        steps.push_back(table_row(K_CINFLIT,    0,  20'hFFFEF, 20'hFFFFF));  // inc and dec cancel
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CINFLIT,    0,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        4,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_ALLOC,      0,  20'hFFFFE, 20'hFFFFF));
        steps.push_back(table_row(K_TAIL,       16, 20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        0,  20'hFFFFF, 20'hFFFFF));
        steps.push_back(table_row(K_CIN,        0,  20'hFFFFF, 20'hFFFFF));
        if (steps.size() != N_TABLE) begin
            stop_run("step table length does not match N_TABLE");
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_available(ovc_available_all, '1);
        check_not_full(assigned_ovc_not_full_all, '1);

        @(posedge clk);
        drive_step(steps[0]);
        for (int s = 0; s < N_TABLE + N_RAND; s++) begin
            @(posedge clk);
            model_update(steps[s]);
            if (steps[s].has_exp && (steps[s].exp_avail != model_avail() ||
                    steps[s].exp_not_full != ~(m_full_q | m_nfg_q))) begin
                stop_run($sformatf("table row %0d disagrees with the reference model", s));
            end
            if (s + 1 < N_TABLE + N_RAND) begin
                if (s + 1 >= steps.size()) steps.push_back(random_step());
                drive_step(steps[s + 1]);
            end else begin
                drive_step('0);
            end
            @(negedge clk);
            check_available(ovc_available_all, model_avail());
            check_not_full(assigned_ovc_not_full_all, ~(m_full_q | m_nfg_q));
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- compile.f
design/router_geom_pkg.sv
design/credit_pkg.sv
design/inport_credit_decode.sv
design/ovc_credit_bank.sv
design/assigned_ovc_full_mask.sv
design/credit_counter_top.sv
bench/credit_counter_tb.sv

//--- design/assigned_ovc_full_mask.sv
`timescale 1ns/1ps

module assigned_ovc_full_mask
    import router_geom_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [V_NUM-1:0] assigned_ovc_num,
    input  logic [P_1-1:0]   dest_port,
    input  logic [VP_1-1:0]  full,
    input  logic [VP_1-1:0]  nearly_full,
    input  logic [VP_1-1:0]  credit_in,
    input  logic             ivc_getting_sw_grant,
    output logic             assigned_ovc_is_full
);

    logic [VP_1-1:0]  full_live;         // flags minus returning credits
    logic [VP_1-1:0]  nearly_full_live;
    logic [V_NUM-1:0] port_full;         // flags of the destination port
    logic [V_NUM-1:0] port_nearly_full;
    logic             sel_full;
    logic             sel_nearly_full;
    logic             full_q;
    logic             nf_grant_q;

    // a credit coming back this cycle frees a slot
    assign full_live        = full & ~credit_in;
    assign nearly_full_live = nearly_full & ~credit_in;

    // one-hot mux on the destination port
    always_comb begin
        port_full        = '0;
        port_nearly_full = '0;
        for (int j = 0; j < P_1; j++) begin
            if (dest_port[j]) begin
                port_full        = port_full | full_live[j*V_NUM +: V_NUM];
                port_nearly_full = port_nearly_full | nearly_full_live[j*V_NUM +: V_NUM];
            end
        end
    end

    // then on the assigned ovc
    always_comb begin
        sel_full        = 1'b0;
        sel_nearly_full = 1'b0;
        for (int v = 0; v < V_NUM; v++) begin
            if (assigned_ovc_num[v]) begin
                sel_full        = sel_full | port_full[v];
                sel_nearly_full = sel_nearly_full | port_nearly_full[v];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_q     <= 1'b0;
            nf_grant_q <= 1'b0;
        end else begin
            full_q     <= sel_full;
            // last credit goes to the flit granted now
            nf_grant_q <= sel_nearly_full & ivc_getting_sw_grant;
        end
    end

    assign assigned_ovc_is_full = full_q | nf_grant_q;

endmodule

//--- design/credit_counter_top.sv
`timescale 1ns/1ps

module credit_counter_top
    import router_geom_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [PV-1:0]    flit_is_tail_all,
    input  logic [PVV-1:0]   assigned_ovc_num_all,
    input  logic [PV-1:0]    ovc_is_assigned_all,
    input  logic [PP_1-1:0]  granted_dest_port_all,
    input  logic [PV-1:0]    first_arbiter_granted_ivc_all,
    input  logic [PV-1:0]    credit_in_all,
    input  logic [PV-1:0]    ovc_allocated_all,
    input  logic [PVP_1-1:0] dest_port_all,
    input  logic [PV-1:0]    ivc_getting_sw_grant,
    output logic [PV-1:0]    ovc_available_all,
    output logic [PV-1:0]    assigned_ovc_not_full_all
);

    logic [VP_1-1:0] credit_dec_port  [P_NUM];  // per source port view
    logic [VP_1-1:0] ovc_rel_port     [P_NUM];
    logic [VP_1-1:0] full_port        [P_NUM];  // source port removed
    logic [VP_1-1:0] nearly_full_port [P_NUM];
    logic [VP_1-1:0] credit_in_port   [P_NUM];
    logic [PV-1:0]   credit_dec_all;
    logic [PV-1:0]   ovc_rel_all;
    logic [PV-1:0]   full_all;
    logic [PV-1:0]   nearly_full_all;
    logic [PV-1:0]   assigned_ovc_is_full_all;

    for (genvar p = 0; p < P_NUM; p++) begin : g_port
        inport_credit_decode i_inport_credit_decode (
            .flit_is_tail              (flit_is_tail_all[p*V_NUM +: V_NUM]),
            .assigned_ovc_num          (assigned_ovc_num_all[p*VV +: VV]),
            .ovc_is_assigned           (ovc_is_assigned_all[p*V_NUM +: V_NUM]),
            .granted_dest_port         (granted_dest_port_all[p*P_1 +: P_1]),
            .first_arbiter_granted_ivc (first_arbiter_granted_ivc_all[p*V_NUM +: V_NUM]),
            .credit_dec                (credit_dec_port[p]),
            .ovc_rel                   (ovc_rel_port[p])
        );

        // group g of source p is port g below p and port g+1 from p on
        for (genvar g = 0; g < P_1; g++) begin : g_slice
            localparam int DST = (g < p) ? g : g + 1;
            assign full_port[p][g*V_NUM +: V_NUM]        = full_all[DST*V_NUM +: V_NUM];
            assign nearly_full_port[p][g*V_NUM +: V_NUM] = nearly_full_all[DST*V_NUM +: V_NUM];
            assign credit_in_port[p][g*V_NUM +: V_NUM]   = credit_in_all[DST*V_NUM +: V_NUM];
        end
    end

    // gather each ovc from every other source port
    for (genvar k = 0; k < PV; k++) begin : g_scatter
        logic [P_1-1:0] dec_src;
        logic [P_1-1:0] rel_src;
        for (genvar j = 0; j < P_NUM; j++) begin : g_src
            if (j < k / V_NUM) begin : g_below
                assign dec_src[j] = credit_dec_port[j][k - V_NUM];
                assign rel_src[j] = ovc_rel_port[j][k - V_NUM];
            end else if (j > k / V_NUM) begin : g_above
                assign dec_src[j-1] = credit_dec_port[j][k];
                assign rel_src[j-1] = ovc_rel_port[j][k];
            end
        end
        assign credit_dec_all[k] = |dec_src;
        assign ovc_rel_all[k]    = |rel_src;
    end

    ovc_credit_bank i_ovc_credit_bank (
        .clk               (clk),
        .reset             (reset),
        .credit_in_all     (credit_in_all),
        .credit_dec_all    (credit_dec_all),
        .ovc_rel_all       (ovc_rel_all),
        .ovc_allocated_all (ovc_allocated_all),
        .full_all          (full_all),
        .nearly_full_all   (nearly_full_all),
        .ovc_available_all (ovc_available_all)
    );

    for (genvar i = 0; i < PV; i++) begin : g_ivc
        assigned_ovc_full_mask i_assigned_ovc_full_mask (
            .clk                  (clk),
            .reset                (reset),
            .assigned_ovc_num     (assigned_ovc_num_all[i*V_NUM +: V_NUM]),
            .dest_port            (dest_port_all[i*P_1 +: P_1]),
            .full                 (full_port[i/V_NUM]),
            .nearly_full          (nearly_full_port[i/V_NUM]),
            .credit_in            (credit_in_port[i/V_NUM]),
            .ivc_getting_sw_grant (ivc_getting_sw_grant[i]),
            .assigned_ovc_is_full (assigned_ovc_is_full_all[i])
        );
    end

    assign assigned_ovc_not_full_all = ~assigned_ovc_is_full_all;

endmodule

//--- design/credit_pkg.sv
package credit_pkg;

    import router_geom_pkg::*;

    // one credit counter value
    typedef logic [CRD_W-1:0] credit_t;

    // allocation state of one ovc
    typedef enum logic {
        OVC_FREE,
        OVC_ALLOCATED
    } ovc_state_e;

    // update applied to one counter in a cycle
    typedef enum logic [1:0] {
        CRD_HOLD,
        CRD_INC,
        CRD_DEC
    } credit_op_e;

    localparam credit_t CRD_MAX = credit_t'(BUF_DEPTH);  // empty downstream buffer

    // at or below this an ovc is not offered for new packets
    localparam credit_t NEARLY_FULL_LIMIT = credit_t'(1);

endpackage

//--- design/inport_credit_decode.sv
`timescale 1ns/1ps

module inport_credit_decode
    import router_geom_pkg::*;
(
    input  logic [V_NUM-1:0] flit_is_tail,
    input  logic [VV-1:0]    assigned_ovc_num,
    input  logic [V_NUM-1:0] ovc_is_assigned,
    input  logic [P_1-1:0]   granted_dest_port,
    input  logic [V_NUM-1:0] first_arbiter_granted_ivc,
    output logic [VP_1-1:0]  credit_dec,
    output logic [VP_1-1:0]  ovc_rel
);

    logic [VV-1:0]    ovc_masked;  // assigned ovc, zero when none
    logic [V_NUM-1:0] sel_ovc;     // ovc of the winning ivc
    logic             sel_tail;    // winner sends its tail

    // drop stale ovc numbers of unassigned ivcs
    always_comb begin
        for (int i = 0; i < V_NUM; i++) begin
            if (ovc_is_assigned[i]) begin
                ovc_masked[i*V_NUM +: V_NUM] = assigned_ovc_num[i*V_NUM +: V_NUM];
            end else begin
                ovc_masked[i*V_NUM +: V_NUM] = '0;
            end
        end
    end

    // one-hot mux over the ivcs of this port
    always_comb begin
        sel_ovc  = '0;
        sel_tail = 1'b0;
        for (int i = 0; i < V_NUM; i++) begin
            if (first_arbiter_granted_ivc[i]) begin
                sel_ovc  = sel_ovc | ovc_masked[i*V_NUM +: V_NUM];
                sel_tail = sel_tail | flit_is_tail[i];
            end
        end
    end

    // put the ovc into the group of the granted output
    always_comb begin
        for (int j = 0; j < P_1; j++) begin
            if (granted_dest_port[j]) begin
                credit_dec[j*V_NUM +: V_NUM] = sel_ovc;
            end else begin
                credit_dec[j*V_NUM +: V_NUM] = '0;
            end
        end
    end

    // the tail flit frees the ovc it used
    always_comb begin
        if (sel_tail) begin
            ovc_rel = credit_dec;
        end else begin
            ovc_rel = '0;
        end
    end

endmodule

//--- design/ovc_credit_bank.sv
`timescale 1ns/1ps

module ovc_credit_bank
    import router_geom_pkg::*, credit_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [PV-1:0] credit_in_all,
    input  logic [PV-1:0] credit_dec_all,
    input  logic [PV-1:0] ovc_rel_all,
    input  logic [PV-1:0] ovc_allocated_all,
    output logic [PV-1:0] full_all,
    output logic [PV-1:0] nearly_full_all,
    output logic [PV-1:0] ovc_available_all
);

    credit_t       crd_cnt  [PV];
    credit_t       crd_next [PV];
    credit_op_e    crd_op   [PV];
    ovc_state_e    ovc_state [PV];
    logic [PV-1:0] dec_all;
    logic [PV-1:0] full_next;
    logic [PV-1:0] nearly_full_next;

    // head flit sent on allocation also takes a credit
    assign dec_all = credit_dec_all | ovc_allocated_all;

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            case ({credit_in_all[k], dec_all[k]})
                2'b10:   crd_op[k] = CRD_INC;
                2'b01:   crd_op[k] = CRD_DEC;
                default: crd_op[k] = CRD_HOLD;  // both cancel out
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            case (crd_op[k])
                CRD_INC: crd_next[k] = crd_cnt[k] + 1'b1;
                CRD_DEC: crd_next[k] = crd_cnt[k] - 1'b1;
                default: crd_next[k] = crd_cnt[k];
            endcase
        end
    end

    // flags follow the next count so they line up with the counter
    always_comb begin
        for (int k = 0; k < PV; k++) begin
            full_next[k]        = (crd_next[k] == '0);
            nearly_full_next[k] = (crd_next[k] <= NEARLY_FULL_LIMIT);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < PV; k++) begin
                crd_cnt[k]   <= CRD_MAX;
                ovc_state[k] <= OVC_FREE;
            end
            full_all        <= '0;
            nearly_full_all <= '0;
        end else begin
            for (int k = 0; k < PV; k++) begin
                crd_cnt[k] <= crd_next[k];
                if (ovc_allocated_all[k]) begin
                    ovc_state[k] <= OVC_ALLOCATED;  // wins over a release
                end else if (ovc_rel_all[k]) begin
                    ovc_state[k] <= OVC_FREE;
                end
            end
            full_all        <= full_next;
            nearly_full_all <= nearly_full_next;
        end
    end

    // non-atomic reuse needs a free ovc with room for more than one flit
    always_comb begin
        for (int k = 0; k < PV; k++) begin
            ovc_available_all[k] = (ovc_state[k] == OVC_FREE) && !nearly_full_all[k];
        end
    end

endmodule

//--- design/router_geom_pkg.sv
package router_geom_pkg;

    // basic router size
    localparam int P_NUM     = 5;  // router ports
    localparam int V_NUM     = 4;  // vcs per port
    localparam int BUF_DEPTH = 4;  // flit slots per downstream vc

    // derived counts
    localparam int PV   = P_NUM * V_NUM;  // all ovcs of the router
    localparam int P_1  = P_NUM - 1;      // ports other than the source
    localparam int VP_1 = V_NUM * P_1;    // ovcs seen from one input port

    // flat bus widths, port major
    localparam int VV    = V_NUM * V_NUM;  // one-hot ovc per ivc, one port
    localparam int PVV   = PV * V_NUM;     // one-hot ovc per ivc, all ports
    localparam int PP_1  = P_NUM * P_1;    // granted output per input port
    localparam int PVP_1 = PV * P_1;       // destination per ivc

    // counter must reach BUF_DEPTH itself
    localparam int CRD_W = $clog2(BUF_DEPTH + 1);

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the credit counter testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module credit_counter_tb \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
